// ==== mpeg_config.svh ====
`ifndef MPEG_CONFIG_SVH
`define MPEG_CONFIG_SVH

// code bytes that follow the 00 00 01 prefix
`define MPEG_PACK_CODE        8'hBA
`define MPEG_END_CODE         8'hB9
`define MPEG_SYS_HEADER_CODE  8'hBB

// padding stream, every byte after the length is payload
`define MPEG_PADDING_ID       8'hBF

// packet header filler before the STD / stamp fields
`define MPEG_STUFFING_BYTE    8'hFF

// single byte time-stamp field meaning no PTS and no DTS
`define MPEG_NO_STAMP_BYTE    8'h0F

`endif

// ==== mpeg_pkg.sv ====
package mpeg_pkg;

   // what the byte after a start-code prefix stands for
   typedef enum logic [1:0]
   {
      code_pack,
      code_end,
      code_sys_header,
      code_packet
   } code_kind_e;

   // decoded time-stamp field of a packet header
   typedef struct packed
   {
      logic        has_pts;
      logic        has_dts;
      logic [32:0] pts;  // 90 kHz units
      logic [32:0] dts;
   } time_stamp_t;

   // optional STD buffer field, two bytes on the wire
   typedef struct packed
   {
      logic        present;
      logic        scale;   // 0: 128 byte units, 1: 1024 byte units
      logic [12:0] size;
   } std_buffer_t;

   // one payload byte tagged with the stream it belongs to
   typedef struct packed
   {
      logic [7:0] stream_id;
      logic [7:0] data;
   } payload_t;

endpackage

// ==== start_code_detector.sv ====
module start_code_detector
(
   input  logic       read_signal,
   input  logic       reset,
   input  logic       arm,
   input  logic [7:0] input_stream,
   output logic       prefix_found
);

   typedef enum logic [1:0]
   {
      sc_search,
      sc_zero,   // one 00 seen
      sc_zeros,  // two or more 00 seen
      sc_found
   } sc_state_e;

   sc_state_e state;

   always_ff @(posedge read_signal)
   begin
      if (reset)
         state <= sc_search;
      else if (!arm)
         state <= sc_search;  // disarmed, forget any partial prefix
      else
      begin
         case (state)
            sc_search:
               if (input_stream == 8'h00)
                  state <= sc_zero;
            sc_zero:
               if (input_stream == 8'h00)
                  state <= sc_zeros;
               else
                  state <= sc_search;
            sc_zeros:
            begin
               // extra leading zeros are legal, stay put
               if (input_stream == 8'h01)
                  state <= sc_found;
               else if (input_stream != 8'h00)
                  state <= sc_search;
            end
            default:
               state <= sc_found;  // held until arm drops
         endcase
      end
   end

   // high while the code byte is on the input
   assign prefix_found = (state == sc_found);

endmodule

// ==== time_stamp_parser.sv ====
module time_stamp_parser
(
   input  logic                  read_signal,
   input  logic                  reset,
   input  logic                  arm,
   input  logic [7:0]            input_stream,
   output logic                  stamp_done,
   output logic [3:0]            stamp_bytes,
   output mpeg_pkg::time_stamp_t time_stamp
);

   logic        busy;
   logic        second;  // working on the DTS half
   logic [2:0]  slot;    // byte index within a 5-byte stamp
   logic [32:0] field;   // value being assembled

   always_ff @(posedge read_signal)
   begin
      if (reset)
      begin
         busy       <= 1'b0;
         second     <= 1'b0;
         slot       <= 3'd0;
         stamp_done <= 1'b0;
      end
      else
      begin
         stamp_done <= 1'b0;

         if (!busy)
         begin
            if (arm)
            begin
               // 0010 -> PTS only, 0011 -> PTS and DTS
               if (input_stream[7:5] == 3'b001)
               begin
                  busy                <= 1'b1;
                  second              <= 1'b0;
                  slot                <= 3'd1;
                  field[32:30]        <= input_stream[3:1];
                  time_stamp.has_pts  <= 1'b1;
                  time_stamp.has_dts  <= input_stream[4];
                  if (!input_stream[4])
                     time_stamp.dts <= '0;
               end
               else
               begin
                  // 0x0F, a lone byte with no stamps
                  time_stamp  <= '0;
                  stamp_bytes <= 4'd1;
                  stamp_done  <= 1'b1;
               end
            end
         end
         else
         begin
            slot <= slot + 3'd1;

            case (slot)
               3'd0:
                  field[32:30] <= input_stream[3:1];  // first DTS byte
               3'd1:
                  field[29:22] <= input_stream;
               3'd2:
                  field[21:15] <= input_stream[7:1];  // bit 0 is a marker
               3'd3:
                  field[14:7] <= input_stream;
               default:
               begin
                  // last byte of a 5-byte group, commit the value
                  if (!second)
                     time_stamp.pts <= {field[32:7], input_stream[7:1]};
                  else
                     time_stamp.dts <= {field[32:7], input_stream[7:1]};

                  if (time_stamp.has_dts && !second)
                  begin
                     second <= 1'b1;
                     slot   <= 3'd0;
                  end
                  else
                  begin
                     busy        <= 1'b0;
                     stamp_done  <= 1'b1;
                     stamp_bytes <= second ? 4'd10 : 4'd5;
                  end
               end
            endcase
         end
      end
   end

endmodule

// ==== packet_parser.sv ====
`include "mpeg_config.svh"

module packet_parser
(
   input  logic                  read_signal,
   input  logic                  reset,
   input  logic                  start,
   input  logic [7:0]            input_stream,
   output logic                  done,
   output logic                  stream_done,
   output logic                  sys_header,
   output logic                  payload_valid,
   output mpeg_pkg::payload_t    payload,
   output logic                  ts_valid,
   output mpeg_pkg::time_stamp_t time_stamp,
   output mpeg_pkg::std_buffer_t std_buffer,
   output logic                  packet_end
);

   typedef enum logic [3:0]
   {
      st_idle,
      st_search,   // waiting on the prefix
      st_len_hi,
      st_len_lo,
      st_stuff,    // stuffing, STD first byte or first stamp byte
      st_std_lo,
      st_stamp,    // stamp field owned by the time-stamp parser
      st_payload,
      st_hold      // pack or end seen, wait for start to drop
   } state_e;

   state_e               state;
   state_e               rearm_state;
   mpeg_pkg::code_kind_e code_kind;

   logic [7:0]  stream_id;
   logic [15:0] count;        // bytes left in the packet
   logic [15:0] length_word;
   logic [15:0] stamp_left;
   logic        end_q;
   logic        prefix_arm;
   logic        prefix_found;
   logic        stamp_arm;
   logic        stamp_done;
   logic        stamp_last;   // stamp field ends the packet
   logic [3:0]  stamp_bytes;

   always_comb
   begin
      case (input_stream)
         `MPEG_PACK_CODE:       code_kind = mpeg_pkg::code_pack;
         `MPEG_END_CODE:        code_kind = mpeg_pkg::code_end;
         `MPEG_SYS_HEADER_CODE: code_kind = mpeg_pkg::code_sys_header;
         default:               code_kind = mpeg_pkg::code_packet;
      endcase
   end

   always_comb
   begin
      if (start)
         rearm_state = st_search;
      else
         rearm_state = st_idle;
   end

   assign length_word = {count[15:8], input_stream};
   assign stamp_left  = count - {12'd0, stamp_bytes};
   assign stamp_last  = stamp_done && (count <= {12'd0, stamp_bytes});

   // stamp field starts on the first byte that is neither stuffing nor STD
   assign stamp_arm = (state == st_stuff) &&
                      (input_stream != `MPEG_STUFFING_BYTE) &&
                      (input_stream[7:6] != 2'b01);

   // an empty packet hands its next byte straight to the prefix search
   assign prefix_arm = (state == st_search) || (stamp_last && start);

   assign ts_valid   = stamp_done;
   assign packet_end = end_q || stamp_last;

   always_ff @(posedge read_signal)
   begin
      if (reset)
      begin
         state         <= st_idle;
         done          <= 1'b0;
         stream_done   <= 1'b0;
         sys_header    <= 1'b0;
         payload_valid <= 1'b0;
         end_q         <= 1'b0;
      end
      else
      begin
         sys_header    <= 1'b0;
         payload_valid <= 1'b0;
         end_q         <= 1'b0;

         case (state)
            st_idle:
               if (start)
                  state <= st_search;
            st_search:
            begin
               if (!start)
                  state <= st_idle;
               else if (prefix_found)
               begin
                  case (code_kind)
                     mpeg_pkg::code_pack:
                     begin
                        done  <= 1'b1;
                        state <= st_hold;
                     end
                     mpeg_pkg::code_end:
                     begin
                        done        <= 1'b1;
                        stream_done <= 1'b1;  // sticky until reset
                        state       <= st_hold;
                     end
                     mpeg_pkg::code_sys_header:
                     begin
                        sys_header <= 1'b1;
                        state      <= st_idle;
                     end
                     default:
                     begin
                        stream_id  <= input_stream;
                        std_buffer <= '0;
                        state      <= st_len_hi;
                     end
                  endcase
               end
            end
            st_len_hi:
            begin
               count <= {input_stream, 8'd0};
               state <= st_len_lo;
            end
            st_len_lo:
            begin
               count <= length_word;
               if (stream_id != `MPEG_PADDING_ID)
                  state <= st_stuff;
               else if (length_word == 16'd0)
               begin
                  end_q <= 1'b1;
                  state <= rearm_state;
               end
               else
                  state <= st_payload;  // padding has no header fields
            end
            st_stuff:
            begin
               if (input_stream == `MPEG_STUFFING_BYTE)
                  count <= count - 16'd1;
               else if (input_stream[7:6] == 2'b01)
               begin
                  std_buffer.present    <= 1'b1;
                  std_buffer.scale      <= input_stream[5];
                  std_buffer.size[12:8] <= input_stream[4:0];
                  count                 <= count - 16'd1;
                  state                 <= st_std_lo;
               end
               else
                  state <= st_stamp;
            end
            st_std_lo:
            begin
               std_buffer.size[7:0] <= input_stream;
               count                <= count - 16'd1;
               state                <= st_stuff;  // stamp byte never looks like 01xx_xxxx
            end
            st_stamp:
            begin
               if (stamp_last)
               begin
                  count <= 16'd0;
                  state <= rearm_state;
               end
               else if (stamp_done)
               begin
                  // this cycle already carries the first payload byte
                  payload_valid     <= 1'b1;
                  payload.stream_id <= stream_id;
                  payload.data      <= input_stream;
                  count             <= stamp_left - 16'd1;
                  if (stamp_left == 16'd1)
                  begin
                     end_q <= 1'b1;
                     state <= rearm_state;
                  end
                  else
                     state <= st_payload;
               end
            end
            st_payload:
            begin
               payload_valid     <= 1'b1;
               payload.stream_id <= stream_id;
               payload.data      <= input_stream;
               count             <= count - 16'd1;
               if (count == 16'd1)
               begin
                  end_q <= 1'b1;
                  state <= rearm_state;
               end
            end
            default:
            begin
               if (!start)
               begin
                  done  <= 1'b0;
                  state <= st_idle;
               end
            end
         endcase
      end
   end

   start_code_detector prefix_i
   (
      .read_signal  (read_signal),
      .reset        (reset),
      .arm          (prefix_arm),
      .input_stream (input_stream),
      .prefix_found (prefix_found)
   );

   time_stamp_parser stamp_i
   (
      .read_signal  (read_signal),
      .reset        (reset),
      .arm          (stamp_arm),
      .input_stream (input_stream),
      .stamp_done   (stamp_done),
      .stamp_bytes  (stamp_bytes),
      .time_stamp   (time_stamp)
   );

endmodule

// ==== stream_reader_top.sv ====
module stream_reader_top
(
   input  logic                  read_signal,
   input  logic                  reset,
   input  logic                  start,
   input  logic [7:0]            input_stream,
   output logic                  done,
   output logic                  stream_done,
   output logic                  sys_header,
   output logic                  payload_valid,
   output mpeg_pkg::payload_t    payload,
   output logic                  ts_valid,
   output mpeg_pkg::time_stamp_t time_stamp,
   output mpeg_pkg::std_buffer_t std_buffer,
   output logic                  packet_end
);

   // one parser, one byte per read_signal edge
   packet_parser parser_i
   (
      .read_signal   (read_signal),
      .reset         (reset),
      .start         (start),
      .input_stream  (input_stream),
      .done          (done),
      .stream_done   (stream_done),
      .sys_header    (sys_header),
      .payload_valid (payload_valid),
      .payload       (payload),
      .ts_valid      (ts_valid),
      .time_stamp    (time_stamp),
      .std_buffer    (std_buffer),
      .packet_end    (packet_end)
   );

endmodule

// ==== stream_reader_checker.sv ====
`include "mpeg_config.svh"

module stream_reader_checker
(
   input logic                  read_signal,
   input logic                  reset,
   input logic                  start,
   input logic [7:0]            input_stream,
   input logic                  done,
   input logic                  stream_done,
   input logic                  sys_header,
   input logic                  payload_valid,
   input mpeg_pkg::payload_t    payload,
   input logic                  ts_valid,
   input mpeg_pkg::time_stamp_t time_stamp,
   input mpeg_pkg::std_buffer_t std_buffer,
   input logic                  packet_end
);

   int          fail_count = 0;  // polled by the testbench
   logic [23:0] hist;            // last three bytes on the wire
   logic [7:0]  cur_id;
   logic [15:0] len;
   logic [15:0] stuff;
   logic [15:0] pay_idx;         // payload bytes seen in this packet
   logic [1:0]  pos;             // 1: length high, 2: length low, 3: header
   logic        in_stuff;
   logic        at_code;
   logic [1:0]  kind;            // 0 no stamp, 1 PTS, 2 PTS and DTS
   logic [15:0] stamp_len;
   logic [15:0] exp_len;
   logic [32:0] exp_pts;

   assign at_code   = start && (hist == 24'h00_0001);
   assign kind      = 2'(cur_id % 8'd3);
   assign stamp_len = (kind == 2'd0) ? 16'd1 : (kind == 2'd1) ? 16'd5 : 16'd10;
   assign exp_pts   = 33'(cur_id) * 33'd1000;
   assign exp_len   = (cur_id == `MPEG_PADDING_ID) ? len : len - stuff - 16'd2 - stamp_len;

   task automatic count_failure(input string what);
      fail_count++;
      $error("%s", what);
   endtask

   always_ff @(posedge read_signal)
   begin
      if (reset)
      begin
         hist     <= '0;
         pos      <= 2'd0;
         pay_idx  <= '0;
         in_stuff <= 1'b0;
      end
      else
      begin
         hist <= {hist[15:0], input_stream};
         if (payload_valid)
            pay_idx <= pay_idx + 16'd1;
         if (at_code)
         begin
            cur_id   <= input_stream;
            pos      <= 2'd1;
            pay_idx  <= '0;
            stuff    <= '0;
            in_stuff <= 1'b1;
         end
         else if (pos == 2'd1)
         begin
            len[15:8] <= input_stream;
            pos       <= 2'd2;
         end
         else if (pos == 2'd2)
         begin
            len[7:0] <= input_stream;
            pos      <= 2'd3;
         end
         else if (pos == 2'd3 && in_stuff)
         begin
            if (input_stream == `MPEG_STUFFING_BYTE)
               stuff <= stuff + 16'd1;
            else
               in_stuff <= 1'b0;  // STD byte ends the filler
         end
      end
   end

   a_reset_low : assert property (@(posedge read_signal) reset |=>
      !(done || stream_done || sys_header || payload_valid || ts_valid || packet_end))
      else count_failure("a control output is high after reset");

   a_done_rise : assert property (@(posedge read_signal) disable iff (reset)
      at_code && (input_stream == `MPEG_PACK_CODE || input_stream == `MPEG_END_CODE) |=> done)
      else count_failure("done did not rise after a pack or end code");

   // held while start stays high
   a_done_hold : assert property (@(posedge read_signal) disable iff (reset)
      done && start |=> done)
      else count_failure("done dropped while start was still high");

   a_done_fall : assert property (@(posedge read_signal) disable iff (reset)
      done && !start |=> !done)
      else count_failure("done stayed high after start dropped");

   // sticky once the end code has gone by
   a_stream_done : assert property (@(posedge read_signal) disable iff (reset)
      stream_done || (at_code && input_stream == `MPEG_END_CODE) |=> stream_done)
      else count_failure("stream_done missing or dropped");

   a_sys_header : assert property (@(posedge read_signal) disable iff (reset)
      sys_header == $past(at_code && input_stream == `MPEG_SYS_HEADER_CODE))
      else count_failure("sys_header pulse wrong");

   a_payload_byte : assert property (@(posedge read_signal) disable iff (reset)
      payload_valid |-> payload.stream_id == cur_id && payload.data == cur_id + pay_idx[7:0])
      else count_failure("payload byte or stream id wrong");

   a_end_count : assert property (@(posedge read_signal) disable iff (reset)
      packet_end |-> pay_idx + {15'd0, payload_valid} == exp_len)
      else count_failure("packet_end at the wrong payload count");

   a_end_present : assert property (@(posedge read_signal) disable iff (reset)
      payload_valid && (pay_idx + 16'd1 == exp_len) |-> packet_end)
      else count_failure("packet_end missing on the last payload byte");

   // packet with no payload ends on the stamp
   a_end_empty : assert property (@(posedge read_signal) disable iff (reset)
      ts_valid && exp_len == 16'd0 |-> packet_end)
      else count_failure("packet_end missing for a packet without payload");

   a_stamp : assert property (@(posedge read_signal) disable iff (reset)
      ts_valid |-> cur_id != `MPEG_PADDING_ID &&
         time_stamp.has_pts == (kind != 2'd0) && time_stamp.has_dts == (kind == 2'd2) &&
         (!time_stamp.has_pts || time_stamp.pts == exp_pts) &&
         (!time_stamp.has_dts || time_stamp.dts == exp_pts + 33'd3000))
      else count_failure("time stamp fields wrong");

   a_std : assert property (@(posedge read_signal) disable iff (reset)
      ts_valid |-> std_buffer.present && std_buffer.scale == cur_id[0] &&
         std_buffer.size == 13'(cur_id) * 13'd3)
      else count_failure("STD buffer fields wrong");

endmodule

bind stream_reader_top stream_reader_checker checker_i
(
   .read_signal   (read_signal),
   .reset         (reset),
   .start         (start),
   .input_stream  (input_stream),
   .done          (done),
   .stream_done   (stream_done),
   .sys_header    (sys_header),
   .payload_valid (payload_valid),
   .payload       (payload),
   .ts_valid      (ts_valid),
   .time_stamp    (time_stamp),
   .std_buffer    (std_buffer),
   .packet_end    (packet_end)
);

// ==== stream_reader_tb.sv ====
`include "mpeg_config.svh"

module stream_reader_tb;

   logic                  read_signal = 1'b0;
   logic                  reset;
   logic                  start;
   logic [7:0]            input_stream;
   logic                  done;
   logic                  stream_done;
   logic                  sys_header;
   logic                  payload_valid;
   mpeg_pkg::payload_t    payload;
   logic                  ts_valid;
   mpeg_pkg::time_stamp_t time_stamp;
   mpeg_pkg::std_buffer_t std_buffer;
   logic                  packet_end;

   logic [7:0] stream_bytes[$];
   bit         hold_flags[$];     // wait for done, then drop start
   integer     seed = 47;
   int         cycles = 0;
   int         cycle_limit = 0;

   stream_reader_top dut_i
   (
      .read_signal   (read_signal),
      .reset         (reset),
      .start         (start),
      .input_stream  (input_stream),
      .done          (done),
      .stream_done   (stream_done),
      .sys_header    (sys_header),
      .payload_valid (payload_valid),
      .payload       (payload),
      .ts_valid      (ts_valid),
      .time_stamp    (time_stamp),
      .std_buffer    (std_buffer),
      .packet_end    (packet_end)
   );

   always #10 read_signal = ~read_signal;

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("tests failed");
      $fatal(1, "simulation stopped");
   endtask

   function automatic int random_below(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   task automatic queue_byte(input logic [7:0] b, input bit hold);
      stream_bytes.push_back(b);
      hold_flags.push_back(hold);
   endtask

   // leading 00 covers the cycle the parser spends leaving idle
   task automatic add_code_unit(input logic [7:0] code, input bit hold);
      queue_byte(8'h00, 1'b0);
      queue_byte(8'h00, 1'b0);
      queue_byte(8'h00, 1'b0);
      queue_byte(8'h01, 1'b0);
      queue_byte(code, hold);
   endtask

   task automatic encode_stamp(input logic [3:0] tag, input logic [32:0] value);
      queue_byte({tag, value[32:30], 1'b1}, 1'b0);
      queue_byte(value[29:22], 1'b0);
      queue_byte({value[21:15], 1'b1}, 1'b0);
      queue_byte(value[14:7], 1'b0);
      queue_byte({value[6:0], 1'b1}, 1'b0);
   endtask

   // stamp kind follows from the id, id mod 3
   task automatic make_packet(input logic [7:0] id, input int stuff, input int pay_len);
      logic [32:0] pts;
      logic [12:0] size;
      int          stamp_len;
      int          length;
      int          k;
      pts       = 33'(id) * 33'd1000;
      size      = 13'(id) * 13'd3;
      stamp_len = (id % 8'd3 == 8'd0) ? 1 : (id % 8'd3 == 8'd1) ? 5 : 10;
      length    = stuff + 2 + stamp_len + pay_len;
      add_code_unit(id, 1'b0);
      queue_byte(8'(length >> 8), 1'b0);
      queue_byte(8'(length), 1'b0);
      for (k = 0; k < stuff; k++)
         queue_byte(`MPEG_STUFFING_BYTE, 1'b0);
      queue_byte({2'b01, id[0], size[12:8]}, 1'b0);
      queue_byte(size[7:0], 1'b0);
      if (stamp_len == 1)
         queue_byte(`MPEG_NO_STAMP_BYTE, 1'b0);
      else if (stamp_len == 5)
         encode_stamp(4'b0010, pts);
      else
      begin
         encode_stamp(4'b0011, pts);
         encode_stamp(4'b0001, pts + 33'd3000);
      end
      for (k = 0; k < pay_len; k++)
         queue_byte(id + 8'(k), 1'b0);
   endtask

   task automatic pad_packet(input int len);
      int k;
      add_code_unit(`MPEG_PADDING_ID, 1'b0);
      queue_byte(8'(len >> 8), 1'b0);
      queue_byte(8'(len), 1'b0);
      for (k = 0; k < len; k++)
         queue_byte(`MPEG_PADDING_ID + 8'(k), 1'b0);
   endtask

   // ids in C0..EF, payload never wraps to a zero byte
   task automatic random_packet(input int kind);
      int stuff;
      int pay_len;
      stuff   = random_below(4);
      pay_len = random_below(13);
      make_packet(8'(192 + 3 * random_below(16) + kind), stuff, pay_len);
   endtask

   task automatic build_stream();
      int p;
      add_code_unit(`MPEG_PACK_CODE, 1'b1);
      for (p = 0; p < 3; p++)
         random_packet(p);  // one of each stamp kind
      for (p = 0; p < 4; p++)
         random_packet(random_below(3));
      add_code_unit(`MPEG_SYS_HEADER_CODE, 1'b0);
      pad_packet(random_below(13));
      pad_packet(0);
      make_packet(8'hC0, 0, 0);  // empty packet, ends on ts_valid
      for (p = 0; p < 4; p++)
         random_packet(random_below(3));
      add_code_unit(`MPEG_PACK_CODE, 1'b1);
      random_packet(random_below(3));
      add_code_unit(`MPEG_END_CODE, 1'b1);
   endtask

   task automatic release_after_done();
      do
      begin
         @(negedge read_signal);
         input_stream = 8'h00;
      end
      while (!done);
      start = 1'b0;
      do
         @(negedge read_signal);
      while (done);
   endtask

   task automatic drive_stream();
      int i;
      for (i = 0; i < stream_bytes.size(); i++)
      begin
         @(negedge read_signal);
         start        = 1'b1;
         input_stream = stream_bytes[i];
         if (hold_flags[i])
            release_after_done();
      end
   endtask

   always @(posedge read_signal)
   begin
      cycles <= cycles + 1;
      if (cycle_limit != 0 && cycles >= cycle_limit)
         stop_on_error($sformatf("run timed out after %0d cycles", cycles));
   end

   always @(negedge read_signal)
   begin
      if (dut_i.checker_i.fail_count != 0)
         stop_on_error($sformatf("FAIL at time %0t: stream checker assertion failed", $time));
   end

   initial
   begin
      reset        = 1'b1;
      start        = 1'b0;
      input_stream = 8'h00;
      build_stream();
      cycle_limit = 4 * stream_bytes.size();
      repeat (4) @(posedge read_signal);
      @(negedge read_signal);
      reset = 1'b0;
      drive_stream();
      repeat (3) @(negedge read_signal);
      if (stream_done && dut_i.checker_i.fail_count == 0)
      begin
         $display("all tests passed");
         $finish;
      end
      else
         stop_on_error($sformatf("FAIL at time %0t: stream_done low or a check failed",
                                 $time));
   end

endmodule

// ==== vlog.f ====
+incdir+.
mpeg_pkg.sv
start_code_detector.sv
time_stamp_parser.sv
packet_parser.sv
stream_reader_top.sv
stream_reader_checker.sv
stream_reader_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f vlog.f --top-module stream_reader_tb -Mdir obj_dir

# the simulator exits non-zero on $fatal, the verdict comes from the output
out=$(./obj_dir/Vstream_reader_tb +verilator+error+limit+100 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^all tests passed$"
then
   exit 0
fi
exit 1
